//--- testbench/usb_bulk_vectors.txt
# endpoint data last phase, all hex, one ingress byte per line
# phase 0 holds the output low, 1 mixes in endpoint 0, 2 runs under back-pressure
3 a0 0 0
3 a1 1 0
1 10 0 0
1 11 0 0
1 12 1 0
2 20 0 0
2 21 1 0
1 13 0 1
1 14 1 1
0 e0 0 1
0 e1 1 1
2 22 1 1
3 a2 1 1
1 30 0 2
1 31 0 2
1 32 0 2
1 33 0 2
1 34 0 2
1 35 0 2
1 36 0 2
1 37 1 2
1 38 0 2
1 39 0 2
1 3a 0 2
1 3b 0 2
1 3c 0 2
1 3d 0 2
1 3e 0 2
1 3f 1 2
1 40 0 2
1 41 0 2
1 42 0 2
1 43 0 2
1 44 0 2
1 45 1 2

//--- usb_bulk_router.f
hdl/usb_bulk_pkg.sv
hdl/ep_credit_if.sv
hdl/ep_drain_if.sv
hdl/ep_steer.sv
hdl/ep_buffer.sv
hdl/ep_merge.sv
hdl/usb_bulk_router.sv
testbench/tb_usb_bulk_router.sv

//--- testbench/tb_usb_bulk_router.sv
`default_nettype none

module tb_usb_bulk_router;
  timeunit 1ns;
  timeprecision 100ps;
  import usb_bulk_pkg::*;

  localparam int unsigned SEED = 32'h646d_1eab;
  localparam string VEC_FILE = "testbench/usb_bulk_vectors.txt";

  logic               clock;
  logic               rst_n_i;
  logic               in_valid_i;
  logic [ENDPT_W-1:0] in_endpt_i;
  logic [DATA_W-1:0]  in_data_i;
  logic               in_last_i;
  logic               in_ready_o;
  logic               out_valid_o;
  logic [ENDPT_W-1:0] out_endpt_o;
  logic [DATA_W-1:0]  out_data_o;
  logic               out_last_o;
  logic               out_ready_i;

  // Ingress vectors as read from the file
  int                vec_endpt [$];
  logic [DATA_W-1:0] vec_data [$];
  logic              vec_last [$];
  int                vec_phase [$];

  // Expected bytes per endpoint with the last flag above the data
  logic [DATA_W:0] exp_q1 [$];
  logic [DATA_W:0] exp_q2 [$];
  logic [DATA_W:0] exp_q3 [$];

  int                 pending;
  int                 sent0_q [$];
  int                 pick_order_q [$];
  bit                 order_built;
  bit                 saw_stall;
  bit                 loaded;
  bit                 in_pkt;
  logic [ENDPT_W-1:0] pkt_endpt;

  usb_bulk_router i_dut (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_endpt_i  (in_endpt_i),
    .in_data_i   (in_data_i),
    .in_last_i   (in_last_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_endpt_o (out_endpt_o),
    .out_data_o  (out_data_o),
    .out_last_o  (out_last_o),
    .out_ready_i (out_ready_i)
  );

  always #5ns clock = ~clock;

  task automatic fail_run(input string why);
    $display("ERROR: %s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  task automatic push_expected(input int ep, input logic [DATA_W:0] v);
    case (ep)
      1: exp_q1.push_back(v);
      2: exp_q2.push_back(v);
      default: exp_q3.push_back(v);
    endcase
  endtask

  task automatic pop_expected(input int ep, output logic [DATA_W:0] v);
    bit found;
    found = 1'b0;
    v = '0;
    if (ep == 1 && exp_q1.size() > 0) begin
      found = 1'b1;
      v = exp_q1.pop_front();
    end else if (ep == 2 && exp_q2.size() > 0) begin
      found = 1'b1;
      v = exp_q2.pop_front();
    end else if (ep == 3 && exp_q3.size() > 0) begin
      found = 1'b1;
      v = exp_q3.pop_front();
    end
    if (!found) fail_run("an output byte arrived with nothing expected on its endpoint");
  endtask

  task automatic load_vectors();
    int    fd;
    int    ep;
    int    dat;
    int    lst;
    int    ph;
    string line;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) fail_run("cannot open the vector file");
    while (!$feof(fd)) begin
      // Comment and blank lines do not scan as four fields
      if ($fgets(line, fd) > 0 && $sscanf(line, "%h %h %h %h", ep, dat, lst, ph) == 4) begin
        vec_endpt.push_back(ep);
        vec_data.push_back(dat[DATA_W-1:0]);
        vec_last.push_back(lst[0]);
        vec_phase.push_back(ph);
      end
    end
    $fclose(fd);
    if (vec_endpt.size() == 0) fail_run("the vector file holds no vectors");
  endtask

  // The idle merger takes the first complete packet and serves the rest round-robin
  task automatic build_pick_order();
    int            prev;
    int            e;
    int            next;
    bit [NUM_EP:1] left;
    left = '0;
    foreach (sent0_q[i]) left[sent0_q[i]] = 1'b1;
    prev = sent0_q[0];
    left[prev] = 1'b0;
    pick_order_q.push_back(prev);
    while (left != '0) begin
      next = 0;
      for (int k = 1; k <= NUM_EP; k++) begin
        e = (prev - 1 + k) % NUM_EP + 1;
        if (next == 0 && left[e]) next = e;
      end
      left[next] = 1'b0;
      pick_order_q.push_back(next);
      prev = next;
    end
    order_built = 1'b1;
  endtask

  // Output monitor
  always @(posedge clock) begin : monitor
    logic [DATA_W:0] got;
    int              want_ep;
    if (rst_n_i && out_valid_o && out_ready_i) begin
      if (out_endpt_o == CTRL_ENDPT) fail_run("an endpoint 0 byte reached the output");
      if (in_pkt) begin
        check_value("packet atomicity", pkt_endpt, out_endpt_o);
      end else if (pick_order_q.size() > 0) begin
        want_ep = pick_order_q.pop_front();
        check_value("round-robin order", want_ep, out_endpt_o);
      end
      pop_expected(out_endpt_o, got);
      check_value("output data", got[DATA_W-1:0], out_data_o);
      check_value("output last", got[DATA_W], out_last_o);
      pending = pending - 1;
      in_pkt = !out_last_o;
      pkt_endpt = out_endpt_o;
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (200 * vec_endpt.size() + 1000) @(posedge clock);
    $display("ERROR: run timed out with %0d bytes still pending", pending);
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

  initial begin : main
    int          idx;
    int          ph;
    bit          gap;
    clock = 1'b0;
    rst_n_i = 1'b0;
    in_valid_i = 1'b0;
    in_endpt_i = ENDPT_W'(1);
    in_data_i = '0;
    in_last_i = 1'b0;
    out_ready_i = 1'b0;
    pending = 0;
    order_built = 1'b0;
    saw_stall = 1'b0;
    in_pkt = 1'b0;
    idx = 0;
    void'($urandom(SEED));
    load_vectors();
    loaded = 1'b1;

    repeat (5) @(posedge clock);
    @(negedge clock);
    rst_n_i = 1'b1;
    repeat (3) begin
      @(posedge clock);
      check_value("reset out_valid_o", 0, out_valid_o);
      check_value("reset in_ready_o", 1, in_ready_o);
    end

    while (idx < vec_endpt.size() || pending != 0) begin
      @(negedge clock);
      ph = (idx < vec_endpt.size()) ? vec_phase[idx] : 3;
      if (ph != 0 && !order_built && sent0_q.size() > 0) build_pick_order();
      case (ph)
        0: out_ready_i = 1'b0;
        1: out_ready_i = ($urandom % 4) != 0;
        2: out_ready_i = ($urandom % 32) == 0;
        default: out_ready_i = 1'b1;
      endcase
      gap = (ph == 1) && (($urandom % 4) == 0);
      in_valid_i = (ph != 3) && !gap;
      if (idx < vec_endpt.size()) begin
        in_endpt_i = ENDPT_W'(vec_endpt[idx]);
        in_data_i = vec_data[idx];
        in_last_i = vec_last[idx];
      end
      @(posedge clock);
      if (in_valid_i) begin
        if (in_endpt_i == CTRL_ENDPT) check_value("endpoint 0 ingress ready", 1, in_ready_o);
        if (in_ready_o) begin
          if (in_endpt_i != CTRL_ENDPT) begin
            push_expected(in_endpt_i, {in_last_i, in_data_i});
            pending = pending + 1;
          end
          if (ph == 0 && in_last_i) sent0_q.push_back(in_endpt_i);
          idx = idx + 1;
        end else begin
          saw_stall = 1'b1;
        end
      end
    end

    // A late extra byte in the quiet window fails in the monitor
    @(negedge clock);
    in_valid_i = 1'b0;
    repeat (20) @(posedge clock);
    if (saw_stall) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("ERROR: in_ready_o never dropped under back-pressure");
      $display("Simulation finished: FAIL");
      $fatal(1, "no back-pressure seen");
    end
  end

endmodule

`default_nettype wire

//--- hdl/usb_bulk_router.sv
`default_nettype none

module usb_bulk_router (
  input  wire logic                          clock,
  input  wire logic                          rst_n_i,

  // Ingress from the packet decoder
  input  wire logic                          in_valid_i,
  input  wire logic [usb_bulk_pkg::ENDPT_W-1:0] in_endpt_i,
  input  wire logic [usb_bulk_pkg::DATA_W-1:0]  in_data_i,
  input  wire logic                          in_last_i,
  output logic                               in_ready_o,

  // Merged egress, tagged with the endpoint
  output logic                               out_valid_o,
  output logic [usb_bulk_pkg::ENDPT_W-1:0]   out_endpt_o,
  output logic [usb_bulk_pkg::DATA_W-1:0]    out_data_o,
  output logic                               out_last_o,
  input  wire logic                          out_ready_i
);
  import usb_bulk_pkg::*;

  ep_credit_if credit_if [NUM_EP] ();
  ep_drain_if  drain_if  [NUM_EP] ();

  ep_steer i_steer (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .in_valid_i (in_valid_i),
    .in_last_i  (in_last_i),
    .in_endpt_i (in_endpt_i),
    .in_data_i  (in_data_i),
    .in_ready_o (in_ready_o),
    .ep_o       (credit_if)
  );

  // Buffer e serves endpoint e + 1
  for (genvar e = 0; e < NUM_EP; e++) begin : g_ep
    ep_buffer i_buffer (
      .clock   (clock),
      .rst_n_i (rst_n_i),
      .push    (credit_if[e]),
      .drain   (drain_if[e])
    );
  end

  ep_merge i_merge (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .ep_i        (drain_if),
    .out_valid_o (out_valid_o),
    .out_last_o  (out_last_o),
    .out_endpt_o (out_endpt_o),
    .out_data_o  (out_data_o),
    .out_ready_i (out_ready_i)
  );

endmodule

`default_nettype wire

//--- hdl/ep_merge.sv
`default_nettype none

module ep_merge (
  input  wire logic                          clock,
  input  wire logic                          rst_n_i,
  ep_drain_if.merge                          ep_i [usb_bulk_pkg::NUM_EP],
  output logic                               out_valid_o,
  output logic                               out_last_o,
  output logic [usb_bulk_pkg::ENDPT_W-1:0]   out_endpt_o,
  output logic [usb_bulk_pkg::DATA_W-1:0]    out_data_o,
  input  wire logic                          out_ready_i
);
  import usb_bulk_pkg::*;

  merge_state_e       state_q;
  logic [ENDPT_W-1:0] sel_q;
  logic [ENDPT_W-1:0] pick_idx;
  logic               pick_found;

  logic [NUM_EP-1:0]  valid_w;
  logic [NUM_EP-1:0]  last_w;
  logic [DATA_W-1:0]  data_w [NUM_EP];

  logic               src_valid;
  logic               src_ready;
  logic               src_fire;
  logic [ENDPT_W-1:0] src_endpt;

  logic               skid_valid_q;
  logic               skid_last_q;
  logic [ENDPT_W-1:0] skid_endpt_q;
  logic [DATA_W-1:0]  skid_data_q;

  logic               out_free;
  logic               out_load;
  logic               skid_load;

  for (genvar e = 0; e < NUM_EP; e++) begin : g_ep
    assign valid_w[e]  = ep_i[e].valid;
    assign last_w[e]   = ep_i[e].last;
    assign data_w[e]   = ep_i[e].data;
    assign ep_i[e].ready = src_ready && (sel_q == ENDPT_W'(e));
  end

  // Round-robin search, the closest buffer after the last winner wins
  always_comb begin
    int idx;
    pick_found = 1'b0;
    pick_idx   = sel_q;
    for (int k = NUM_EP; k >= 1; k--) begin
      idx = (int'(sel_q) + k) % NUM_EP;
      if (valid_w[idx]) begin
        pick_found = 1'b1;
        pick_idx   = ENDPT_W'(idx);
      end
    end
  end

  assign src_valid = valid_w[sel_q];
  assign src_ready = (state_q == MG_SEND) && !skid_valid_q;
  assign src_fire  = src_valid && src_ready;
  assign src_endpt = sel_q + 1'b1;

  // Output stage with a skid register behind it
  assign out_free  = !out_valid_o || out_ready_i;
  assign out_load  = out_free && (skid_valid_q || src_fire);
  assign skid_load = !out_free && src_fire;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= MG_PICK;
      sel_q        <= ENDPT_W'(NUM_EP - 1);
      out_valid_o  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      case (state_q)
        MG_PICK: begin
          if (pick_found) begin
            sel_q   <= pick_idx;
            state_q <= MG_SEND;
          end
        end
        MG_SEND: begin
          if (src_fire && last_w[sel_q]) begin
            state_q <= MG_PICK;
          end
        end
        default: state_q <= MG_PICK;
      endcase

      if (out_free) begin
        out_valid_o  <= skid_valid_q || src_fire;
        skid_valid_q <= 1'b0;
      end else if (src_fire) begin
        skid_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (skid_load) begin
      skid_data_q  <= data_w[sel_q];
      skid_last_q  <= last_w[sel_q];
      skid_endpt_q <= src_endpt;
    end
    if (out_load) begin
      if (skid_valid_q) begin
        out_data_o  <= skid_data_q;
        out_last_o  <= skid_last_q;
        out_endpt_o <= skid_endpt_q;
      end else begin
        out_data_o  <= data_w[sel_q];
        out_last_o  <= last_w[sel_q];
        out_endpt_o <= src_endpt;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/ep_buffer.sv
`default_nettype none

module ep_buffer (
  input  wire logic   clock,
  input  wire logic   rst_n_i,
  ep_credit_if.buffer push,
  ep_drain_if.buffer  drain
);
  import usb_bulk_pkg::*;

  // Last flag stored above the data byte
  logic [DATA_W:0]     mem [EP_DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [CREDIT_W-1:0] pkt_cnt_q;
  logic                credit_q;

  logic                wr_en;
  logic                rd_en;
  logic                push_done;
  logic                pop_done;

  assign wr_en = push.push_valid;
  assign rd_en = drain.valid && drain.ready;

  // Packet boundaries seen on each side
  assign push_done = wr_en && push.push_last;
  assign pop_done  = rd_en && drain.last;

  // The packet being drained stays counted until its last byte leaves,
  // so a partly drained packet keeps valid high
  assign drain.valid = (pkt_cnt_q != '0);
  assign drain.data  = mem[rd_ptr_q][DATA_W-1:0];
  assign drain.last  = mem[rd_ptr_q][DATA_W];

  assign push.credit_o = credit_q;

  // Storage, no overflow check since the steerer holds the credits
  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= {push.push_last, push.push_data};
    end
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Complete packets held in the FIFO
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pkt_cnt_q <= '0;
    end else begin
      case ({push_done, pop_done})
        2'b10:   pkt_cnt_q <= pkt_cnt_q + 1'b1;
        2'b01:   pkt_cnt_q <= pkt_cnt_q - 1'b1;
        default: pkt_cnt_q <= pkt_cnt_q;
      endcase
    end
  end

  // One credit back to the steerer per released byte
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= rd_en;
    end
  end

endmodule

`default_nettype wire

//--- hdl/ep_steer.sv
`default_nettype none

module ep_steer (
  input  wire logic                          clock,
  input  wire logic                          rst_n_i,
  input  wire logic                          in_valid_i,
  input  wire logic                          in_last_i,
  input  wire logic [usb_bulk_pkg::ENDPT_W-1:0] in_endpt_i,
  input  wire logic [usb_bulk_pkg::DATA_W-1:0]  in_data_i,
  output logic                               in_ready_o,
  ep_credit_if.steer                         ep_o [usb_bulk_pkg::NUM_EP]
);
  import usb_bulk_pkg::*;

  steer_state_e       state_q;
  logic [ENDPT_W-1:0] endpt_q;
  logic [ENDPT_W-1:0] cur_endpt;
  logic               drop_path;
  logic               accept;

  logic [NUM_EP-1:0]   sel;
  logic [NUM_EP-1:0]   has_credit;
  logic [NUM_EP-1:0]   push;
  logic [NUM_EP-1:0]   credit_in;
  logic [CREDIT_W-1:0] credit_q [NUM_EP];

  // The endpoint comes from the bus on a first byte, then from the latch
  assign cur_endpt = (state_q == ST_IDLE) ? in_endpt_i : endpt_q;

  assign drop_path = (state_q == ST_DROP) ||
                     ((state_q == ST_IDLE) && (in_endpt_i == CTRL_ENDPT));

  // Control endpoint bytes are always taken and go nowhere
  assign in_ready_o = drop_path || |(sel & has_credit);
  assign accept     = in_valid_i && in_ready_o;

  for (genvar e = 0; e < NUM_EP; e++) begin : g_ep
    assign sel[e]        = !drop_path && (cur_endpt == ENDPT_W'(e + 1));
    assign has_credit[e] = (credit_q[e] != '0);
    assign push[e]       = accept && sel[e];

    assign ep_o[e].push_valid = push[e];
    assign ep_o[e].push_data  = in_data_i;
    assign ep_o[e].push_last  = in_last_i;
    assign credit_in[e]       = ep_o[e].credit_o;

    // A push and a returned credit in the same cycle cancel out
    always_ff @(posedge clock or negedge rst_n_i) begin
      if (!rst_n_i) begin
        credit_q[e] <= CREDIT_W'(EP_DEPTH);
      end else begin
        case ({push[e], credit_in[e]})
          2'b10:   credit_q[e] <= credit_q[e] - 1'b1;
          2'b01:   credit_q[e] <= credit_q[e] + 1'b1;
          default: credit_q[e] <= credit_q[e];
        endcase
      end
    end
  end

  // Packet framing
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      endpt_q <= CTRL_ENDPT;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            endpt_q <= in_endpt_i;
            // Single-byte packets never leave idle
            if (!in_last_i) begin
              state_q <= drop_path ? ST_DROP : ST_PASS;
            end
          end
        end
        ST_PASS, ST_DROP: begin
          if (accept && in_last_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/ep_drain_if.sv
`default_nettype none

interface ep_drain_if;
  import usb_bulk_pkg::*;

  logic              valid;
  logic [DATA_W-1:0] data;
  logic              last;
  logic              ready;

  modport buffer (
    output valid,
    output data,
    output last,
    input  ready
  );

  modport merge (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

//--- hdl/ep_credit_if.sv
`default_nettype none

interface ep_credit_if;
  import usb_bulk_pkg::*;

  // Byte push from the steerer, qualified by push_valid
  logic              push_valid;
  logic [DATA_W-1:0] push_data;
  logic              push_last;

  // One pulse per byte released by the buffer
  logic              credit_o;

  modport steer (
    output push_valid,
    output push_data,
    output push_last,
    input  credit_o
  );

  modport buffer (
    input  push_valid,
    input  push_data,
    input  push_last,
    output credit_o
  );

endinterface

`default_nettype wire

//--- hdl/usb_bulk_pkg.sv
`default_nettype none

package usb_bulk_pkg;

  // Bulk OUT endpoints 1 to 3, served by one buffer each
  localparam int NUM_EP = 3;

  // Endpoint number and byte width on the streams
  localparam int ENDPT_W = 2;
  localparam int DATA_W = 8;

  // Buffer depth in bytes, also the credit count after reset
  localparam int EP_DEPTH = 16;

  // Credit counters must reach EP_DEPTH itself
  localparam int CREDIT_W = 5;
  localparam int PTR_W = 4;

  // Control endpoint traffic is discarded by the steerer
  localparam logic [ENDPT_W-1:0] CTRL_ENDPT = '0;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PASS,
    ST_DROP
  } steer_state_e;

  typedef enum logic {
    MG_PICK,
    MG_SEND
  } merge_state_e;

endpackage

`default_nettype wire
